// File: verif/socPatterns.txt
# columns: op address data byteEnable expected, all hex
# op: W write, R read vs expected, M read vs ram model, G read vs lfsr model, I wait irq, C irq low
R 2000 00000000 0 00000001
G 2000 00000000 0 00000000
W 0000 11223344 f 00000000
W 0000 aabbccdd 5 00000000
M 0000 00000000 0 00000000
W 0004 deadbeef f 00000000
W 0004 00000000 8 00000000
M 0004 00000000 0 00000000
W 0008 01020304 f 00000000
W 0008 a5a5a5a5 6 00000000
R 0008 00000000 0 01a5a504
W 2000 c0ffee11 f 00000000
R 2000 00000000 0 c0ffee11
G 2000 00000000 0 00000000
G 2000 00000000 0 00000000
G 2000 00000000 0 00000000
W 2000 00000000 f 00000000
G 2000 00000000 0 00000000
G 2000 00000000 0 00000000
W 1004 00000005 f 00000000
W 1000 00000003 f 00000000
I 0000 00000000 0 00000000
R 100c 00000000 0 00000001
W 1000 00000002 f 00000000
W 100c 00000001 f 00000000
C 0000 00000000 0 00000000
W 1000 00000000 f 00000000
C 0000 00000000 0 00000000
W 0010 aabbccdd f 00000000
W 3010 11111111 f 00000000
M 0010 00000000 0 00000000
R 0010 00000000 0 aabbccdd
R 3000 00000000 0 00000000
R f010 00000000 0 00000000

// File: sources.f
hw/socPkg.sv
hw/busIf.sv
hw/busController.sv
hw/ram.sv
hw/timer.sv
hw/random.sv
hw/socTop.sv
verif/socTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sources.f --top-module socTb \
    --Mdir obj_dir -o socSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/socSim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Testbench passed"; then
    exit 0
fi
echo "pass line missing from simulation output"
exit 1

// File: verif/socTb.sv
`timescale 1ns/1ps
`default_nettype none

module socTb
    import socPkg::*;
();

    localparam int busTimeout = 20;
    localparam int irqTimeout = 200;
    // several periods of the timer set up by the patterns
    localparam int quietCycles = 32;
    // ram words used by the random phase
    localparam ramAddrT windowBase = 8'h80;

    logic   clk;
    logic   rst;
    logic   read;
    logic   write;
    addrT   address;
    dataT   writeData;
    byteEnT byteEnable;
    logic   waitRequest;
    logic   readValid;
    dataT   readData;
    logic   irq;

    // reference models
    dataT ramModel [256];
    dataT lfsrModel;
    // stimulus generator state
    dataT fibState;

    socTop i_socTop (
        .clk         (clk),
        .rst         (rst),
        .read        (read),
        .write       (write),
        .address     (address),
        .writeData   (writeData),
        .byteEnable  (byteEnable),
        .waitRequest (waitRequest),
        .readValid   (readValid),
        .readData    (readData),
        .irq         (irq)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stopWithFailure();
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkData(input string name, input dataT expected, input dataT actual);
        if (actual !== expected) begin
            $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
            stopWithFailure();
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("MISMATCH time=%0t signal=%s expected=%b actual=%b",
                     $time, name, expected, actual);
            stopWithFailure();
        end
    endtask

    // one galois step shifts right and folds in the taps when a one drops out
    function automatic dataT galoisStep(input dataT s);
        return (s >> 1) ^ (s[0] ? randomTaps : 32'h0);
    endfunction

    // only enabled byte lanes take the new data
    function automatic dataT mergeLanes(input dataT old, input dataT data, input byteEnT be);
        dataT merged;
        merged = old;
        for (int lane = 0; lane < 4; lane++) begin
            if (be[lane]) begin
                merged[lane*8 +: 8] = data[lane*8 +: 8];
            end
        end
        return merged;
    endfunction

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic dataT drawBits(input int n);
        dataT v;
        logic fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb       = fibState[31] ^ fibState[21] ^ fibState[1] ^ fibState[0];
            fibState = {fibState[30:0], fb};
            v        = {v[30:0], fb};
        end
        return v;
    endfunction

    // single bus access that holds the strobe until the stall drops
    task automatic busAccess(input logic isRead, input addrT addr, input dataT data,
                             input byteEnT be, output dataT rdata);
        int cycles;
        @(posedge clk);
        read       <= isRead;
        write      <= !isRead;
        address    <= addr;
        writeData  <= data;
        byteEnable <= be;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > busTimeout) begin
                $display("timeout: waitRequest never dropped for address %h", addr);
                stopWithFailure();
            end
        end while (waitRequest);
        // readValid is high in the completion cycle only for reads
        checkBit("readValid", isRead, readValid);
        rdata = readData;
        @(posedge clk);
        read  <= 1'b0;
        write <= 1'b0;
    endtask

    task automatic waitIrq();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > irqTimeout) begin
                $display("timeout: irq never rose");
                stopWithFailure();
            end
        end while (!irq);
    endtask

    // irq has to stay low over the whole window
    task automatic watchIrqLow();
        for (int k = 0; k < quietCycles; k++) begin
            @(negedge clk);
            checkBit("irq", 1'b0, irq);
        end
    endtask

    // one pattern line
    task automatic runOp(input logic [7:0] op, input addrT addr, input dataT data,
                         input byteEnT be, input dataT expected);
        dataT   got;
        regionT region;
        region = addr[15:12];
        case (op)
            "W": begin
                busAccess(1'b0, addr, data, be, got);
                if (region == ramRegion) begin
                    ramModel[addr[9:2]] = mergeLanes(ramModel[addr[9:2]], data, be);
                end else if (region == randomRegion) begin
                    // zero seed reloads the reset value
                    lfsrModel = (data == '0) ? randomReset : data;
                end
            end
            "R", "M", "G": begin
                busAccess(1'b1, addr, data, be, got);
                if (op == "R") begin
                    checkData("readData", expected, got);
                end else if (op == "M") begin
                    checkData("readData", ramModel[addr[9:2]], got);
                end else begin
                    checkData("readData", lfsrModel, got);
                end
                // every random read advances the lfsr
                if (region == randomRegion) begin
                    lfsrModel = galoisStep(lfsrModel);
                end
            end
            "I": waitIrq();
            "C": watchIrqLow();
            default: begin
                $display("unknown pattern opcode %c", op);
                stopWithFailure();
            end
        endcase
    endtask

    initial begin
        int         fd;
        int         fields;
        int         i;
        string      line;
        logic [7:0] op;
        addrT       addr;
        dataT       data;
        byteEnT     be;
        dataT       expected;
        dataT       got;
        dataT       draw;
        ramAddrT    idx;

        rst        = 1'b1;
        read       = 1'b0;
        write      = 1'b0;
        address    = '0;
        writeData  = '0;
        byteEnable = '0;
        lfsrModel  = randomReset;
        fibState   = 32'ha5af_b629;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // bus quiet right after reset
        @(negedge clk);
        checkBit("waitRequest", 1'b0, waitRequest);
        checkBit("readValid", 1'b0, readValid);
        checkBit("irq", 1'b0, irq);

        fd = $fopen("verif/socPatterns.txt", "r");
        if (fd == 0) begin
            $display("could not open verif/socPatterns.txt");
            stopWithFailure();
        end
        while ($fgets(line, fd) > 0) begin
            // skip comment and blank lines
            if ((line.len() > 1) && (line[0] != "#")) begin
                fields = $sscanf(line, "%c %h %h %h %h", op, addr, data, be, expected);
                if (fields != 5) begin
                    $display("malformed pattern line: %s", line);
                    stopWithFailure();
                end
                runOp(op, addr, data, be, expected);
            end
        end
        $fclose(fd);

        // full-word fill of the window with values tied to the whole index
        for (i = 0; i < 16; i++) begin
            idx  = windowBase + ramAddrT'(i);
            data = {~idx, idx ^ 8'h5a, idx, idx ^ 8'hc3};
            addr = {6'd0, idx, 2'b00};
            busAccess(1'b0, addr, data, 4'hf, got);
            ramModel[idx] = data;
        end

        // random writes and checked reads inside the window
        for (i = 0; i < 32; i++) begin
            draw = drawBits(4);
            idx  = windowBase + {4'd0, draw[3:0]};
            addr = {6'd0, idx, 2'b00};
            data = drawBits(32);
            draw = drawBits(5);
            be   = draw[3:0];
            if (draw[4]) begin
                busAccess(1'b0, addr, data, be, got);
                ramModel[idx] = mergeLanes(ramModel[idx], data, be);
            end else begin
                busAccess(1'b1, addr, data, be, got);
                checkData("readData", ramModel[idx], got);
            end
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/socTop.sv
`timescale 1ns/1ps
`default_nettype none

module socTop
    import socPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   read,
    input  logic   write,
    input  addrT   address,
    input  dataT   writeData,
    input  byteEnT byteEnable,
    output logic   waitRequest,
    output logic   readValid,
    output dataT   readData,
    output logic   irq
);

    // one port per device
    busIf ramBus ();
    busIf timerBus ();
    busIf randomBus ();

    busController
    busController (
        .clk,
        .rst,
        .read,
        .write,
        .address,
        .writeData,
        .byteEnable,
        .waitRequest,
        .readValid,
        .readData,
        .ramBus        (ramBus.host),
        .timerBus      (timerBus.host),
        .randomBus     (randomBus.host)
    );

    ram
    ram (
        .clk,
        .rst,
        .bus           (ramBus.device)
    );

    // timer interrupt leaves as a plain pin
    timer
    timer (
        .clk,
        .rst,
        .bus           (timerBus.device),
        .irq
    );

    random
    random (
        .clk,
        .rst,
        .bus           (randomBus.device)
    );

endmodule

`default_nettype wire

// File: hw/random.sv
`timescale 1ns/1ps
`default_nettype none

module random
    import socPkg::*;
(
    input  logic clk,
    input  logic rst,
    busIf.device bus
);

    dataT lfsr;
    dataT lfsrNext;

    // galois step, shift right and fold in taps on a one
    assign lfsrNext = lfsr[0] ? ((lfsr >> 1) ^ randomTaps) : (lfsr >> 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr          <= randomReset;
            bus.readValid <= 1'b0;
        end else begin
            bus.readValid <= bus.read;
            if (bus.write) begin
                // zero would lock the lfsr
                lfsr <= (bus.writeData == '0) ? randomReset : bus.writeData;
            end else if (bus.read) begin
                lfsr <= lfsrNext;
            end
        end
    end

    // value before the step goes out
    always_ff @(posedge clk) begin
        if (bus.read) begin
            bus.readData <= lfsr;
        end
    end

endmodule

`default_nettype wire

// File: hw/timer.sv
`timescale 1ns/1ps
`default_nettype none

module timer
    import socPkg::*;
(
    input  logic clk,
    input  logic rst,
    busIf.device bus,
    output logic irq
);

    logic    countEn;
    logic    irqEn;
    dataT    compare;
    dataT    count;
    logic    flag;
    logic    hit;
    regAddrT sel;

    // timer only decodes the low two index bits
    assign sel = bus.regAddr[1:0];

    // period reached
    assign hit = countEn && (count == compare);

    always_ff @(posedge clk) begin
        if (rst) begin
            countEn <= 1'b0;
            irqEn   <= 1'b0;
            compare <= '1;
            count   <= '0;
            flag    <= 1'b0;
            irq     <= 1'b0;
        end else begin
            // control and compare, full word writes
            if (bus.write && (sel == timerControl)) begin
                countEn <= bus.writeData[0];
                irqEn   <= bus.writeData[1];
            end
            if (bus.write && (sel == timerCompare)) begin
                compare <= bus.writeData;
            end
            // software load beats counting
            if (bus.write && (sel == timerCount)) begin
                count <= bus.writeData;
            end else if (hit) begin
                count <= '0;
            end else if (countEn) begin
                count <= count + 1'b1;
            end
            // sticky flag, a new hit wins over write-one-to-clear
            if (hit) begin
                flag <= 1'b1;
            end else if (bus.write && (sel == timerStatus) && bus.writeData[0]) begin
                flag <= 1'b0;
            end
            irq <= flag && irqEn;
        end
    end

    // register readback
    always_ff @(posedge clk) begin
        if (bus.read) begin
            case (sel)
                timerControl: bus.readData <= {30'd0, irqEn, countEn};
                timerCompare: bus.readData <= compare;
                timerCount:   bus.readData <= count;
                default:      bus.readData <= {31'd0, flag};
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bus.readValid <= 1'b0;
        end else begin
            bus.readValid <= bus.read;
        end
    end

endmodule

`default_nettype wire

// File: hw/ram.sv
`timescale 1ns/1ps
`default_nettype none

module ram
    import socPkg::*;
(
    input  logic clk,
    input  logic rst,
    busIf.device bus
);

    localparam int depth = 256;

    dataT mem [depth];

    // byte-lane write, only enabled lanes change
    always_ff @(posedge clk) begin
        if (bus.write) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (bus.byteEnable[lane]) begin
                    mem[bus.regAddr][lane*8 +: 8] <= bus.writeData[lane*8 +: 8];
                end
            end
        end
    end

    // registered read data
    always_ff @(posedge clk) begin
        if (bus.read) begin
            bus.readData <= mem[bus.regAddr];
        end
    end

    // valid one cycle after the strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            bus.readValid <= 1'b0;
        end else begin
            bus.readValid <= bus.read;
        end
    end

endmodule

`default_nettype wire

// File: hw/busController.sv
`timescale 1ns/1ps
`default_nettype none

module busController
    import socPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   read,
    input  logic   write,
    input  addrT   address,
    input  dataT   writeData,
    input  byteEnT byteEnable,
    output logic   waitRequest,
    output logic   readValid,
    output dataT   readData,
    busIf.host     ramBus,
    busIf.host     timerBus,
    busIf.host     randomBus
);

    busStateT state;
    logic     opRead;
    regionT   regionR;
    ramAddrT  indexR;
    dataT     writeDataR;
    byteEnT   byteEnableR;
    dataT     readDataR;
    logic     mapped;
    logic     issueRead;
    logic     issueWrite;
    logic     deviceValid;
    dataT     deviceData;

    // only three regions have a device behind them
    assign mapped = (address[15:12] == ramRegion) || (address[15:12] == timerRegion) ||
                    (address[15:12] == randomRegion);

    // stall the master until the access is done
    assign waitRequest = (read || write) && (state != finish);
    assign readValid   = (state == finish) && opRead;
    assign readData    = readDataR;

    // strobe pulse, single cycle in issue
    assign issueRead  = (state == issue) && opRead;
    assign issueWrite = (state == issue) && !opRead;

    assign ramBus.read       = issueRead && (regionR == ramRegion);
    assign ramBus.write      = issueWrite && (regionR == ramRegion);
    assign timerBus.read     = issueRead && (regionR == timerRegion);
    assign timerBus.write    = issueWrite && (regionR == timerRegion);
    assign randomBus.read    = issueRead && (regionR == randomRegion);
    assign randomBus.write   = issueWrite && (regionR == randomRegion);

    // payload fanned out to every port, strobes pick the target
    assign ramBus.regAddr       = indexR;
    assign ramBus.writeData     = writeDataR;
    assign ramBus.byteEnable    = byteEnableR;
    assign timerBus.regAddr     = indexR;
    assign timerBus.writeData   = writeDataR;
    assign timerBus.byteEnable  = byteEnableR;
    assign randomBus.regAddr    = indexR;
    assign randomBus.writeData  = writeDataR;
    assign randomBus.byteEnable = byteEnableR;

    // return path from the selected device
    always_comb begin
        case (regionR)
            ramRegion: begin
                deviceValid = ramBus.readValid;
                deviceData  = ramBus.readData;
            end
            timerRegion: begin
                deviceValid = timerBus.readValid;
                deviceData  = timerBus.readData;
            end
            randomRegion: begin
                deviceValid = randomBus.readValid;
                deviceData  = randomBus.readData;
            end
            default: begin
                deviceValid = 1'b0;
                deviceData  = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= idle;
            opRead <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (read || write) begin
                        opRead <= read;
                        // unmapped accesses skip the device
                        state  <= mapped ? issue : finish;
                    end
                end
                issue:   state <= opRead ? pending : finish;
                pending: begin
                    if (deviceValid) begin
                        state <= finish;
                    end
                end
                finish:  state <= idle;
                default: state <= idle;
            endcase
        end
    end

    // capture decode while idle, read data while pending
    always_ff @(posedge clk) begin
        if (state == idle) begin
            regionR     <= address[15:12];
            indexR      <= address[9:2];
            writeDataR  <= writeData;
            byteEnableR <= byteEnable;
            // zero stays for unmapped reads
            readDataR   <= '0;
        end else if ((state == pending) && deviceValid) begin
            readDataR   <= deviceData;
        end
    end

endmodule

`default_nettype wire

// File: hw/busIf.sv
`timescale 1ns/1ps
`default_nettype none

// one peripheral port between the controller and a device
interface busIf
    import socPkg::*;
();

    // controller side
    logic    read;
    logic    write;
    ramAddrT regAddr;
    dataT    writeData;
    byteEnT  byteEnable;

    // device side
    dataT    readData;
    logic    readValid;

    modport host (
        output read, write, regAddr, writeData, byteEnable,
        input  readData, readValid
    );

    modport device (
        input  read, write, regAddr, writeData, byteEnable,
        output readData, readValid
    );

endinterface

`default_nettype wire

// File: hw/socPkg.sv
`default_nettype none

package socPkg;

    // bus word and address widths
    typedef logic [31:0] dataT;
    typedef logic [15:0] addrT;
    typedef logic [3:0]  byteEnT;

    // device-side index widths
    typedef logic [7:0]  ramAddrT;
    typedef logic [1:0]  regAddrT;

    // address bits 15:12 pick the device
    typedef logic [3:0]  regionT;

    localparam regionT ramRegion    = 4'd0;
    localparam regionT timerRegion  = 4'd1;
    localparam regionT randomRegion = 4'd2;

    // timer register map
    localparam regAddrT timerControl = 2'd0;
    localparam regAddrT timerCompare = 2'd1;
    localparam regAddrT timerCount   = 2'd2;
    localparam regAddrT timerStatus  = 2'd3;

    // lfsr value after reset, also replaces a zero seed
    localparam dataT randomReset = 32'h0000_0001;
    // galois feedback mask
    localparam dataT randomTaps  = 32'h8020_0003;

    typedef enum logic [1:0] {idle, issue, pending, finish} busStateT;

endpackage

`default_nettype wire
